/* common/ecdsa_pkg.sv */
package ecdsa_pkg;

  localparam int DAT_BITS         = 64;
  localparam int SCALAR_BITS      = 256;
  localparam int WORDS_PER_SCALAR = SCALAR_BITS / DAT_BITS;

  // secp256k1 group order
  localparam logic [SCALAR_BITS-1:0] CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  typedef logic [DAT_BITS-1:0]    word_t;
  typedef logic [SCALAR_BITS-1:0] scalar_t;

  localparam logic [7:0] CMD_VERIFY_SCALARS = 8'h10;
  localparam logic [7:0] RPL_VERIFY_SCALARS = 8'h11;

  // cmd sits in the lowest byte of the first word
  typedef struct packed {
    logic [39:0] rsvd;
    logic [15:0] len;
    logic [7:0]  cmd;
  } header_t;

  typedef struct packed {
    logic timeout_fail;
    logic out_of_range_r;
    logic out_of_range_s;
  } ver_status_t;

  // Header, index, then s, r and z
  localparam int VERIFY_WORDS = 2 + 3 * WORDS_PER_SCALAR;
  // Header, index, status, then u1 and u2
  localparam int RPL_WORDS    = 3 + 2 * WORDS_PER_SCALAR;

endpackage

/* scalar/bin_inv.sv */
`timescale 1ns/1ps

module bin_inv import ecdsa_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_abort,
  input  scalar_t i_dat,
  input  logic    i_val,
  output logic    o_rdy,
  output scalar_t o_dat,
  output logic    o_val,
  input  logic    i_rdy
);

  typedef enum logic [1:0] {I_IDLE, I_RUN, I_DONE} inv_state_t;

  inv_state_t state;
  scalar_t    u;
  scalar_t    v;
  scalar_t    x1;
  scalar_t    x2;
  logic       u_one;
  logic       v_one;

  // x/2 mod n, n is odd
  function automatic scalar_t half_mod(input scalar_t x);
    logic [SCALAR_BITS:0] t;
    t = x[0] ? {1'b0, x} + {1'b0, CURVE_N} : {1'b0, x};
    return t[SCALAR_BITS:1];
  endfunction

  function automatic scalar_t sub_mod(input scalar_t a, input scalar_t b);
    logic [SCALAR_BITS:0] t;
    t = {1'b0, a} - {1'b0, b};
    if (a < b)
      t = t + {1'b0, CURVE_N};
    return t[SCALAR_BITS-1:0];
  endfunction

  assign o_rdy = (state == I_IDLE);
  assign o_val = (state == I_DONE);
  assign u_one = (u == scalar_t'(1));
  assign v_one = (v == scalar_t'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= I_IDLE;
    end else if (i_abort) begin
      state <= I_IDLE;
    end else begin
      case (state)
        I_IDLE: if (i_val) state <= I_RUN;
        I_RUN: if (u_one || v_one) state <= I_DONE;
        I_DONE: if (i_rdy) state <= I_IDLE;
        default: state <= I_IDLE;
      endcase
    end
  end

  // Invariant x1*a = u and x2*a = v (mod n)
  always_ff @(posedge i_clk) begin
    if (state == I_IDLE) begin
      u  <= i_dat;
      v  <= CURVE_N;
      x1 <= scalar_t'(1);
      x2 <= '0;
    end else if (state == I_RUN) begin
      if (u_one) begin
        o_dat <= x1;
      end else if (v_one) begin
        o_dat <= x2;
      end else if (!u[0]) begin
        u  <= u >> 1;
        x1 <= half_mod(x1);
      end else if (!v[0]) begin
        v  <= v >> 1;
        x2 <= half_mod(x2);
      end else if (u >= v) begin
        // Difference of two odd values is even, halve in the same step
        u  <= (u - v) >> 1;
        x1 <= half_mod(sub_mod(x1, x2));
      end else begin
        v  <= (v - u) >> 1;
        x2 <= half_mod(sub_mod(x2, x1));
      end
    end
  end

endmodule

/* scalar/mod_mult.sv */
`timescale 1ns/1ps

module mod_mult import ecdsa_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  scalar_t i_a,
  input  scalar_t i_b,
  input  logic    i_val,
  output logic    o_rdy,
  output scalar_t o_dat,
  output logic    o_val,
  input  logic    i_rdy
);

  localparam logic [SCALAR_BITS+1:0] N_X1 = {2'b00, CURVE_N};
  localparam logic [SCALAR_BITS+1:0] N_X2 = {1'b0, CURVE_N, 1'b0};

  typedef enum logic [1:0] {M_IDLE, M_RUN, M_DONE} mult_state_t;

  mult_state_t                    state;
  logic [$clog2(SCALAR_BITS+1)-1:0] cnt;
  scalar_t                        a_q;
  scalar_t                        b_q;
  scalar_t                        acc;
  logic [SCALAR_BITS+1:0]         acc_sum;
  scalar_t                        acc_red;

  assign o_rdy = (state == M_IDLE);
  assign o_val = (state == M_DONE);
  assign o_dat = acc;

  // acc*2 + a is below 3n, so two compares finish the reduction
  always_comb begin
    acc_sum = {1'b0, acc, 1'b0} + (b_q[SCALAR_BITS-1] ? {2'b00, a_q} : '0);
    if (acc_sum >= N_X2)
      acc_red = scalar_t'(acc_sum - N_X2);
    else if (acc_sum >= N_X1)
      acc_red = scalar_t'(acc_sum - N_X1);
    else
      acc_red = scalar_t'(acc_sum);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= M_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        M_IDLE: begin
          cnt <= '0;
          if (i_val)
            state <= M_RUN;
        end
        M_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == SCALAR_BITS)
            state <= M_DONE;
        end
        M_DONE: if (i_rdy) state <= M_IDLE;
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == M_IDLE) begin
      a_q <= i_a;
      b_q <= i_b;
      acc <= '0;
    end else if (state == M_RUN && cnt != SCALAR_BITS) begin
      acc <= acc_red;
      b_q <= b_q << 1;
    end
  end

endmodule

/* scalar/scalar_seq.sv */
`timescale 1ns/1ps

module scalar_seq import ecdsa_pkg::*; #(
  parameter int TIMEOUT_BITS = 12
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  word_t       i_job_index,
  input  scalar_t     i_job_s,
  input  scalar_t     i_job_r,
  input  scalar_t     i_job_z,
  input  logic        i_job_val,
  output logic        o_job_rdy,
  output word_t       o_res_index,
  output scalar_t     o_res_u1,
  output scalar_t     o_res_u2,
  output ver_status_t o_res_status,
  output logic        o_res_val,
  input  logic        i_res_rdy
);

  typedef enum logic [2:0] {S_IDLE, S_INV, S_MUL_U2, S_MUL_U1, S_DONE} seq_state_t;

  seq_state_t              state;
  logic [TIMEOUT_BITS-1:0] tmo_cnt;
  logic                    busy;
  logic                    tmo_hit;
  logic                    job_take;
  logic                    s_bad;
  logic                    r_bad;
  scalar_t                 s_q;
  scalar_t                 z_q;
  logic                    inv_val;
  logic                    inv_rdy;
  logic                    inv_abort;
  scalar_t                 inv_out;
  logic                    inv_out_val;
  logic                    inv_out_rdy;
  scalar_t                 mul_a;
  scalar_t                 mul_b;
  scalar_t                 mul_out;
  logic                    mul_val;
  logic                    mul_rdy;
  logic                    mul_out_val;
  logic                    mul_take;

  assign o_job_rdy   = (state == S_IDLE);
  assign o_res_val   = (state == S_DONE);
  assign job_take    = i_job_val && o_job_rdy;
  assign s_bad       = (i_job_s >= CURVE_N);
  assign r_bad       = (i_job_r >= CURVE_N);
  assign busy        = (state == S_INV) || (state == S_MUL_U2) || (state == S_MUL_U1);
  assign tmo_hit     = busy && (&tmo_cnt);
  assign inv_out_rdy = (state == S_INV);
  // A product that shows up before the next launch is taken belongs to an aborted job
  assign mul_take    = mul_out_val && !mul_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= S_IDLE;
      tmo_cnt      <= '0;
      inv_val      <= 1'b0;
      inv_abort    <= 1'b0;
      mul_val      <= 1'b0;
      o_res_status <= '0;
    end else begin
      inv_abort <= 1'b0;
      if (inv_val && inv_rdy)
        inv_val <= 1'b0;
      if (mul_val && mul_rdy)
        mul_val <= 1'b0;
      if (busy)
        tmo_cnt <= tmo_cnt + 1'b1;

      case (state)
        S_IDLE: begin
          tmo_cnt <= '0;
          if (job_take) begin
            o_res_status <= '{timeout_fail: 1'b0, out_of_range_r: r_bad, out_of_range_s: s_bad};
            if (s_bad || r_bad) begin
              state <= S_DONE;
            end else begin
              inv_val <= 1'b1;
              state   <= S_INV;
            end
          end
        end
        S_INV: begin
          if (inv_out_val) begin
            mul_val <= 1'b1;
            state   <= S_MUL_U2;
          end
        end
        S_MUL_U2: begin
          if (mul_take) begin
            mul_val <= 1'b1;
            state   <= S_MUL_U1;
          end
        end
        S_MUL_U1: begin
          if (mul_take)
            state <= S_DONE;
        end
        S_DONE: begin
          if (i_res_rdy)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase

      // Stuck job, give up and report it
      if (tmo_hit) begin
        inv_abort                 <= 1'b1;
        inv_val                   <= 1'b0;
        mul_val                   <= 1'b0;
        o_res_status.timeout_fail <= 1'b1;
        state                     <= S_DONE;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (job_take) begin
      o_res_index <= i_job_index;
      s_q         <= i_job_s;
      mul_a       <= i_job_r;
      // Hash may exceed n once at most
      z_q         <= (i_job_z >= CURVE_N) ? i_job_z - CURVE_N : i_job_z;
      o_res_u1    <= '0;
      o_res_u2    <= '0;
    end
    if (state == S_INV && inv_out_val)
      mul_b <= inv_out;
    if (state == S_MUL_U2 && mul_take) begin
      o_res_u2 <= mul_out;
      mul_a    <= z_q;
    end
    if (state == S_MUL_U1 && mul_take)
      o_res_u1 <= mul_out;
    if (tmo_hit) begin
      o_res_u1 <= '0;
      o_res_u2 <= '0;
    end
  end

  bin_inv u_bin_inv (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_abort (inv_abort),
    .i_dat   (s_q),
    .i_val   (inv_val),
    .o_rdy   (inv_rdy),
    .o_dat   (inv_out),
    .o_val   (inv_out_val),
    .i_rdy   (inv_out_rdy)
  );

  mod_mult u_mod_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_a   (mul_a),
    .i_b   (mul_b),
    .i_val (mul_val),
    .o_rdy (mul_rdy),
    .o_dat (mul_out),
    .o_val (mul_out_val),
    .i_rdy (1'b1)
  );

endmodule

/* hw/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser import ecdsa_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  word_t   i_cmd_dat,
  input  logic    i_cmd_val,
  input  logic    i_cmd_sop,
  input  logic    i_cmd_eop,
  output logic    o_cmd_rdy,
  output word_t   o_job_index,
  output scalar_t o_job_s,
  output scalar_t o_job_r,
  output scalar_t o_job_z,
  output logic    o_job_val,
  input  logic    i_job_rdy
);

  localparam int S_FIRST   = 2;
  localparam int R_FIRST   = S_FIRST + WORDS_PER_SCALAR;
  localparam int Z_FIRST   = R_FIRST + WORDS_PER_SCALAR;
  localparam int LAST_WORD = VERIFY_WORDS - 1;

  typedef enum logic [1:0] {P_IDLE, P_COLLECT, P_IGNORE, P_HOLD} parse_state_t;

  parse_state_t state;
  logic [3:0]   cnt;
  logic [1:0]   wsel;
  logic         cmd_take;
  logic         job_done;
  header_t      hdr;

  assign hdr       = i_cmd_dat;
  assign o_cmd_rdy = (state != P_HOLD);
  assign cmd_take  = i_cmd_val && o_cmd_rdy;
  assign job_done  = o_job_val && i_job_rdy;
  // Word position inside the current scalar
  assign wsel      = 2'(cnt - 4'(S_FIRST));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= P_IDLE;
      cnt       <= '0;
      o_job_val <= 1'b0;
    end else begin
      if (job_done)
        o_job_val <= 1'b0;
      case (state)
        P_IDLE: begin
          if (cmd_take && !i_cmd_eop) begin
            cnt <= 4'd1;
            if (i_cmd_sop && hdr.cmd == CMD_VERIFY_SCALARS)
              state <= P_COLLECT;
            else
              state <= P_IGNORE;
          end
        end
        P_COLLECT: begin
          if (cmd_take) begin
            cnt <= cnt + 4'd1;
            if (cnt == 4'(LAST_WORD)) begin
              o_job_val <= 1'b1;
              state     <= i_cmd_eop ? P_HOLD : P_IGNORE;
            end else if (i_cmd_eop) begin
              // Short command, drop it
              state <= P_IDLE;
            end
          end
        end
        P_IGNORE: begin
          if (cmd_take && i_cmd_eop)
            state <= (o_job_val && !i_job_rdy) ? P_HOLD : P_IDLE;
        end
        P_HOLD: begin
          if (job_done)
            state <= P_IDLE;
        end
        default: state <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_take && state == P_COLLECT) begin
      if (cnt < 4'(S_FIRST))
        o_job_index <= i_cmd_dat;
      else if (cnt < 4'(R_FIRST))
        o_job_s[wsel*DAT_BITS +: DAT_BITS] <= i_cmd_dat;
      else if (cnt < 4'(Z_FIRST))
        o_job_r[wsel*DAT_BITS +: DAT_BITS] <= i_cmd_dat;
      else
        o_job_z[wsel*DAT_BITS +: DAT_BITS] <= i_cmd_dat;
    end
  end

endmodule

/* hw/reply_tx.sv */
`timescale 1ns/1ps

module reply_tx import ecdsa_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  input  word_t       i_res_index,
  input  scalar_t     i_res_u1,
  input  scalar_t     i_res_u2,
  input  ver_status_t i_res_status,
  input  logic        i_res_val,
  output logic        o_res_rdy,
  output word_t       o_rpl_dat,
  output logic        o_rpl_val,
  output logic        o_rpl_sop,
  output logic        o_rpl_eop,
  input  logic        i_rpl_rdy
);

  localparam int U1_FIRST = 3;
  localparam int U2_FIRST = U1_FIRST + WORDS_PER_SCALAR;

  logic        busy;
  logic [3:0]  cnt;
  logic [1:0]  wsel;
  word_t       index_q;
  scalar_t     u1_q;
  scalar_t     u2_q;
  ver_status_t status_q;
  header_t     hdr;

  assign o_res_rdy = !busy;
  assign o_rpl_val = busy;
  assign o_rpl_sop = busy && (cnt == 4'd0);
  assign o_rpl_eop = busy && (cnt == 4'(RPL_WORDS - 1));
  assign wsel      = 2'(cnt - 4'(U1_FIRST));

  always_comb begin
    hdr     = '0;
    hdr.cmd = RPL_VERIFY_SCALARS;
    hdr.len = 16'(RPL_WORDS);
    if (cnt == 4'd0)
      o_rpl_dat = hdr;
    else if (cnt == 4'd1)
      o_rpl_dat = index_q;
    else if (cnt == 4'd2)
      o_rpl_dat = {{(DAT_BITS - $bits(ver_status_t)){1'b0}}, status_q};
    else if (cnt < 4'(U2_FIRST))
      o_rpl_dat = u1_q[wsel*DAT_BITS +: DAT_BITS];
    else
      o_rpl_dat = u2_q[wsel*DAT_BITS +: DAT_BITS];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (!busy) begin
      cnt <= '0;
      if (i_res_val)
        busy <= 1'b1;
    end else if (i_rpl_rdy) begin
      // Step only on an accepted word
      cnt <= cnt + 4'd1;
      if (o_rpl_eop)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_res_val && !busy) begin
      index_q  <= i_res_index;
      u1_q     <= i_res_u1;
      u2_q     <= i_res_u2;
      status_q <= i_res_status;
    end
  end

endmodule

/* hw/ecdsa_scalar_top.sv */
`timescale 1ns/1ps

module ecdsa_scalar_top import ecdsa_pkg::*; #(
  parameter int TIMEOUT_BITS = 12
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  word_t i_cmd_dat,
  input  logic  i_cmd_val,
  input  logic  i_cmd_sop,
  input  logic  i_cmd_eop,
  output logic  o_cmd_rdy,
  output word_t o_rpl_dat,
  output logic  o_rpl_val,
  output logic  o_rpl_sop,
  output logic  o_rpl_eop,
  input  logic  i_rpl_rdy
);

  // Parser to sequencer
  word_t       job_index;
  scalar_t     job_s;
  scalar_t     job_r;
  scalar_t     job_z;
  logic        job_val;
  logic        job_rdy;

  // Sequencer to reply
  word_t       res_index;
  scalar_t     res_u1;
  scalar_t     res_u2;
  ver_status_t res_status;
  logic        res_val;
  logic        res_rdy;

  cmd_parser u_cmd_parser (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd_dat   (i_cmd_dat),
    .i_cmd_val   (i_cmd_val),
    .i_cmd_sop   (i_cmd_sop),
    .i_cmd_eop   (i_cmd_eop),
    .o_cmd_rdy   (o_cmd_rdy),
    .o_job_index (job_index),
    .o_job_s     (job_s),
    .o_job_r     (job_r),
    .o_job_z     (job_z),
    .o_job_val   (job_val),
    .i_job_rdy   (job_rdy)
  );

  scalar_seq #(
    .TIMEOUT_BITS (TIMEOUT_BITS)
  ) u_scalar_seq (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_job_index  (job_index),
    .i_job_s      (job_s),
    .i_job_r      (job_r),
    .i_job_z      (job_z),
    .i_job_val    (job_val),
    .o_job_rdy    (job_rdy),
    .o_res_index  (res_index),
    .o_res_u1     (res_u1),
    .o_res_u2     (res_u2),
    .o_res_status (res_status),
    .o_res_val    (res_val),
    .i_res_rdy    (res_rdy)
  );

  reply_tx u_reply_tx (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_res_index  (res_index),
    .i_res_u1     (res_u1),
    .i_res_u2     (res_u2),
    .i_res_status (res_status),
    .i_res_val    (res_val),
    .o_res_rdy    (res_rdy),
    .o_rpl_dat    (o_rpl_dat),
    .o_rpl_val    (o_rpl_val),
    .o_rpl_sop    (o_rpl_sop),
    .o_rpl_eop    (o_rpl_eop),
    .i_rpl_rdy    (i_rpl_rdy)
  );

endmodule

/* testbench/tb_ecdsa_scalar.sv */
`timescale 1ns/1ps

module tb_ecdsa_scalar import ecdsa_pkg::*; ();

  // Eight jobs, one of them runs into the 4096-cycle timeout, plus margin
  localparam int MAX_CYCLES = 60000;
  localparam int REPLY_WAIT = 5000;

  logic  i_clk;
  logic  i_rst;
  word_t i_cmd_dat;
  logic  i_cmd_val;
  logic  i_cmd_sop;
  logic  i_cmd_eop;
  logic  o_cmd_rdy;
  word_t o_rpl_dat;
  logic  o_rpl_val;
  logic  o_rpl_sop;
  logic  o_rpl_eop;
  logic  i_rpl_rdy;

  int          val_errs;
  int          proto_errs;
  int          cycles;
  int          word_pos;
  int          rpl_done;
  bit          rdy_random;
  int unsigned seed_init;
  word_t       cmd_words[$];
  word_t       rpl_words[$];
  word_t       got[RPL_WORDS];

  ecdsa_scalar_top #(.TIMEOUT_BITS(12)) u_ecdsa_scalar_top (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd_dat (i_cmd_dat),
    .i_cmd_val (i_cmd_val),
    .i_cmd_sop (i_cmd_sop),
    .i_cmd_eop (i_cmd_eop),
    .o_cmd_rdy (o_cmd_rdy),
    .o_rpl_dat (o_rpl_dat),
    .o_rpl_val (o_rpl_val),
    .o_rpl_sop (o_rpl_sop),
    .o_rpl_eop (o_rpl_eop),
    .i_rpl_rdy (i_rpl_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // Random ready pattern and capture of accepted reply words
  always @(negedge i_clk) begin
    i_rpl_rdy = rdy_random ? 1'($urandom % 2) : 1'b1;
    if (!i_rst && o_rpl_val && i_rpl_rdy) begin
      if (o_rpl_sop !== (word_pos == 0)) begin
        proto_errs++;
        $display("Reply word %0d has a wrong sop flag at %0t", word_pos, $time);
      end
      if (o_rpl_eop !== (word_pos == RPL_WORDS - 1)) begin
        proto_errs++;
        $display("Reply word %0d has a wrong eop flag at %0t", word_pos, $time);
      end
      rpl_words.push_back(o_rpl_dat);
      if (word_pos == RPL_WORDS - 1) begin
        word_pos = 0;
        rpl_done++;
      end else begin
        word_pos++;
      end
    end
  end

  function automatic scalar_t mulmod(input scalar_t a, input scalar_t b);
    logic [2*SCALAR_BITS-1:0] p;
    p = {{SCALAR_BITS{1'b0}}, a} * {{SCALAR_BITS{1'b0}}, b};
    p = p % {{SCALAR_BITS{1'b0}}, CURVE_N};
    return p[SCALAR_BITS-1:0];
  endfunction

  // Fermat inverse, n is prime
  function automatic scalar_t powmod(input scalar_t b, input scalar_t e);
    scalar_t acc;
    int      i;
    acc = scalar_t'(1);
    for (i = SCALAR_BITS - 1; i >= 0; i--) begin
      acc = mulmod(acc, acc);
      if (e[i])
        acc = mulmod(acc, b);
    end
    return acc;
  endfunction

  function automatic scalar_t rand_scalar();
    scalar_t x;
    int      i;
    for (i = 0; i < SCALAR_BITS / 32; i++)
      x[i*32 +: 32] = $urandom;
    return x;
  endfunction

  function automatic scalar_t rand_below_n();
    scalar_t x;
    x = rand_scalar();
    if (x >= CURVE_N)
      x = x - CURVE_N;
    if (x == '0)
      x = scalar_t'(1);
    return x;
  endfunction

  function automatic scalar_t gather(input int first);
    scalar_t x;
    int      k;
    for (k = 0; k < WORDS_PER_SCALAR; k++)
      x[k*DAT_BITS +: DAT_BITS] = got[first + k];
    return x;
  endfunction

  task automatic check_word(input word_t got_w, input word_t exp_w, input string what);
    if (got_w !== exp_w) begin
      val_errs++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got_w, exp_w);
    end
  endtask

  task automatic check_scalar(input scalar_t got_x, input scalar_t exp_x, input string what);
    if (got_x !== exp_x) begin
      val_errs++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got_x, exp_x);
    end
  endtask

  task automatic check_status(input ver_status_t got_st, input ver_status_t exp_st);
    if (got_st !== exp_st) begin
      val_errs++;
      $display("[ERROR] %0t: status is %b, expected %b", $time, got_st, exp_st);
    end
  endtask

  task automatic build_verify(input word_t index, input scalar_t s, input scalar_t r,
                              input scalar_t z);
    header_t hdr;
    int      k;
    hdr     = '0;
    hdr.cmd = CMD_VERIFY_SCALARS;
    hdr.len = 16'(VERIFY_WORDS);
    cmd_words.delete();
    cmd_words.push_back(hdr);
    cmd_words.push_back(index);
    for (k = 0; k < WORDS_PER_SCALAR; k++)
      cmd_words.push_back(s[k*DAT_BITS +: DAT_BITS]);
    for (k = 0; k < WORDS_PER_SCALAR; k++)
      cmd_words.push_back(r[k*DAT_BITS +: DAT_BITS]);
    for (k = 0; k < WORDS_PER_SCALAR; k++)
      cmd_words.push_back(z[k*DAT_BITS +: DAT_BITS]);
  endtask

  task automatic send_cmd();
    int i;
    i = 0;
    while (i < cmd_words.size()) begin
      @(negedge i_clk);
      i_cmd_val = 1'b1;
      i_cmd_dat = cmd_words[i];
      i_cmd_sop = (i == 0);
      i_cmd_eop = (i == cmd_words.size() - 1);
      // Ready only changes on a rising edge
      if (o_cmd_rdy)
        i++;
    end
    @(negedge i_clk);
    i_cmd_val = 1'b0;
    i_cmd_sop = 1'b0;
    i_cmd_eop = 1'b0;
  endtask

  task automatic take_reply(output bit ok);
    int waited;
    int k;
    waited = 0;
    while (rpl_done == 0 && waited < REPLY_WAIT) begin
      @(posedge i_clk);
      waited++;
    end
    ok = (rpl_done != 0);
    if (!ok) begin
      proto_errs++;
      $display("No reply arrived within %0d cycles at %0t", REPLY_WAIT, $time);
    end else begin
      rpl_done--;
      for (k = 0; k < RPL_WORDS; k++)
        got[k] = rpl_words.pop_front();
    end
  endtask

  task automatic check_reply(input word_t index, input scalar_t s, input scalar_t r,
                             input scalar_t z);
    header_t     exp_hdr;
    ver_status_t exp_st;
    scalar_t     w;
    scalar_t     exp_u1;
    scalar_t     exp_u2;
    exp_hdr     = '0;
    exp_hdr.cmd = RPL_VERIFY_SCALARS;
    exp_hdr.len = 16'(RPL_WORDS);
    exp_st      = '0;
    exp_u1      = '0;
    exp_u2      = '0;
    exp_st.out_of_range_s = (s >= CURVE_N);
    exp_st.out_of_range_r = (r >= CURVE_N);
    if (!exp_st.out_of_range_s && !exp_st.out_of_range_r) begin
      if (s == '0) begin
        // Zero has no inverse, the job can only time out
        exp_st.timeout_fail = 1'b1;
      end else begin
        w      = powmod(s, CURVE_N - 2);
        exp_u1 = mulmod(z, w);
        exp_u2 = mulmod(r, w);
      end
    end
    check_word(got[0], exp_hdr, "reply header");
    check_word(got[1], index, "reply index");
    check_status(ver_status_t'(got[2][2:0]), exp_st);
    check_word(got[2] >> $bits(ver_status_t), word_t'(0), "status upper bits");
    check_scalar(gather(3), exp_u1, "u1");
    check_scalar(gather(3 + WORDS_PER_SCALAR), exp_u2, "u2");
  endtask

  task automatic run_verify(input word_t index, input scalar_t s, input scalar_t r,
                            input scalar_t z);
    bit ok;
    build_verify(index, s, r, z);
    send_cmd();
    take_reply(ok);
    if (ok)
      check_reply(index, s, r, z);
  endtask

  task automatic test_valid_job();
    run_verify(64'h100, rand_below_n(), rand_below_n(), rand_scalar());
  endtask

  task automatic test_out_of_range();
    run_verify(64'h200, CURVE_N + 256'd5, rand_below_n(), rand_scalar());
    run_verify(64'h201, rand_below_n(), '1, rand_scalar());
  endtask

  task automatic test_zero_s();
    run_verify(64'h300, '0, rand_below_n(), rand_scalar());
  endtask

  task automatic test_dropped_cmds();
    header_t hdr;
    hdr     = '0;
    hdr.cmd = 8'h5A;
    hdr.len = 16'd4;
    cmd_words.delete();
    cmd_words.push_back(hdr);
    cmd_words.push_back(64'h400);
    cmd_words.push_back({$urandom, $urandom});
    cmd_words.push_back({$urandom, $urandom});
    send_cmd();
    // Verify command that ends inside r
    build_verify(64'h401, rand_below_n(), rand_below_n(), rand_scalar());
    while (cmd_words.size() > 8)
      cmd_words.delete(cmd_words.size() - 1);
    send_cmd();
    run_verify(64'h402, rand_below_n(), rand_below_n(), rand_scalar());
  endtask

  task automatic test_back_to_back();
    scalar_t s_list[3];
    scalar_t r_list[3];
    scalar_t z_list[3];
    bit      ok;
    int      j;
    rdy_random = 1'b1;
    for (j = 0; j < 3; j++) begin
      s_list[j] = rand_below_n();
      r_list[j] = rand_below_n();
      z_list[j] = rand_scalar();
      build_verify(64'h500 + j, s_list[j], r_list[j], z_list[j]);
      send_cmd();
    end
    for (j = 0; j < 3; j++) begin
      take_reply(ok);
      if (ok)
        check_reply(64'h500 + j, s_list[j], r_list[j], z_list[j]);
    end
    rdy_random = 1'b0;
  endtask

  initial begin
    seed_init  = $urandom(32'he336);
    val_errs   = 0;
    proto_errs = 0;
    cycles     = 0;
    word_pos   = 0;
    rpl_done   = 0;
    rdy_random = 1'b0;
    i_rst      = 1'b1;
    i_cmd_dat  = '0;
    i_cmd_val  = 1'b0;
    i_cmd_sop  = 1'b0;
    i_cmd_eop  = 1'b0;
    i_rpl_rdy  = 1'b0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    test_valid_job();
    test_out_of_range();
    test_zero_s();
    test_dropped_cmds();
    test_back_to_back();

    repeat (100) @(posedge i_clk);
    if (rpl_done != 0 || rpl_words.size() != 0 || word_pos != 0) begin
      proto_errs++;
      $display("Extra reply words arrived after the last test: %0d", rpl_words.size());
    end

    $display("Value errors: %0d, protocol errors: %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* compile.f */
common/ecdsa_pkg.sv
scalar/bin_inv.sv
scalar/mod_mult.sv
scalar/scalar_seq.sv
hw/cmd_parser.sv
hw/reply_tx.sv
hw/ecdsa_scalar_top.sv
testbench/tb_ecdsa_scalar.sv
